//--- hdl/tl_pkg.sv
package tl_pkg;

  // Memory channel widths
  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned OP_WIDTH   = 3;

  // Host tag in the low bits, host index above it
  localparam int unsigned HOST_SOURCE_WIDTH = 1;
  localparam int unsigned SOURCE_WIDTH      = 2;
  localparam int unsigned HOST_IDX_WIDTH    = SOURCE_WIDTH - HOST_SOURCE_WIDTH;

  localparam int unsigned NUM_HOSTS   = 2;
  localparam int unsigned HOST_ICACHE = 0;
  localparam int unsigned HOST_DCACHE = 1;

  // A channel opcodes
  localparam logic [OP_WIDTH-1:0] OP_PUT_FULL = 3'd0;
  localparam logic [OP_WIDTH-1:0] OP_GET      = 3'd4;

  // D channel opcodes
  localparam logic [OP_WIDTH-1:0] OP_ACCESS_ACK      = 3'd0;
  localparam logic [OP_WIDTH-1:0] OP_ACCESS_ACK_DATA = 3'd1;

endpackage

//--- hdl/hpm_pkg.sv
package hpm_pkg;

  localparam int unsigned HPM_EVENT_NUM = 8;

  // Internal event indices
  localparam int unsigned HPM_EVENT_NONE          = 0;
  localparam int unsigned HPM_EVENT_ICACHE_ACCESS = 1;
  localparam int unsigned HPM_EVENT_DCACHE_ACCESS = 2;
  localparam int unsigned HPM_EVENT_MEM_STALL     = 3;

  // Everything from here up passes through from outside
  localparam int unsigned HPM_EXT_FIRST = 4;

  localparam int unsigned HPM_COUNTER_WIDTH = 32;

endpackage

//--- hdl/tl_host_arbiter.sv
`timescale 1ns/1ps

module tl_host_arbiter (
  input  logic clk_i,
  input  logic rst_n_i,

  // Host A channels, one slice per host
  input  logic [tl_pkg::NUM_HOSTS-1:0]                              host_a_valid_i,
  output logic [tl_pkg::NUM_HOSTS-1:0]                              host_a_ready_o,
  input  logic [tl_pkg::NUM_HOSTS-1:0][tl_pkg::OP_WIDTH-1:0]        host_a_opcode_i,
  input  logic [tl_pkg::NUM_HOSTS-1:0][tl_pkg::ADDR_WIDTH-1:0]      host_a_address_i,
  input  logic [tl_pkg::NUM_HOSTS-1:0][tl_pkg::HOST_SOURCE_WIDTH-1:0] host_a_source_i,
  input  logic [tl_pkg::NUM_HOSTS-1:0][tl_pkg::DATA_WIDTH-1:0]      host_a_data_i,

  // Memory A channel
  output logic                            mem_a_valid_o,
  input  logic                            mem_a_ready_i,
  output logic [tl_pkg::OP_WIDTH-1:0]     mem_a_opcode_o,
  output logic [tl_pkg::ADDR_WIDTH-1:0]   mem_a_address_o,
  output logic [tl_pkg::SOURCE_WIDTH-1:0] mem_a_source_o,
  output logic [tl_pkg::DATA_WIDTH-1:0]   mem_a_data_o
);

  import tl_pkg::*;

  logic [HOST_IDX_WIDTH-1:0] rr_ptr_q;
  logic                      lock_q;
  logic [HOST_IDX_WIDTH-1:0] lock_idx_q;
  logic [HOST_IDX_WIDTH-1:0] pick_idx;
  logic [HOST_IDX_WIDTH-1:0] grant_idx;
  logic                      mem_a_fire;

  // Search for a requester starting at the pointer
  always_comb begin
    logic [HOST_IDX_WIDTH-1:0] cand;
    logic                      found;
    found = 1'b0;
    pick_idx = rr_ptr_q;
    for (int i = 0; i < NUM_HOSTS; i++) begin
      cand = rr_ptr_q + HOST_IDX_WIDTH'(i);
      if (!found && host_a_valid_i[cand]) begin
        pick_idx = cand;
        found = 1'b1;
      end
    end
  end

  // A stalled beat keeps its winner until it transfers
  assign grant_idx = lock_q ? lock_idx_q : pick_idx;

  assign mem_a_valid_o   = host_a_valid_i[grant_idx];
  assign mem_a_opcode_o  = host_a_opcode_i[grant_idx];
  assign mem_a_address_o = host_a_address_i[grant_idx];
  assign mem_a_data_o    = host_a_data_i[grant_idx];
  assign mem_a_source_o  = {grant_idx, host_a_source_i[grant_idx]};

  assign mem_a_fire = mem_a_valid_o && mem_a_ready_i;

  always_comb begin
    for (int h = 0; h < NUM_HOSTS; h++) begin
      host_a_ready_o[h] = mem_a_ready_i && (grant_idx == HOST_IDX_WIDTH'(h));
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rr_ptr_q   <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      lock_q     <= mem_a_valid_o && !mem_a_ready_i;
      lock_idx_q <= grant_idx;
      // Next search starts just past the winner
      if (mem_a_fire) begin
        rr_ptr_q <= grant_idx + HOST_IDX_WIDTH'(1);
      end
    end
  end

endmodule

//--- hdl/tl_resp_router.sv
`timescale 1ns/1ps

module tl_resp_router (
  // Memory D channel
  input  logic                            mem_d_valid_i,
  output logic                            mem_d_ready_o,
  input  logic [tl_pkg::OP_WIDTH-1:0]     mem_d_opcode_i,
  input  logic [tl_pkg::SOURCE_WIDTH-1:0] mem_d_source_i,
  input  logic [tl_pkg::DATA_WIDTH-1:0]   mem_d_data_i,

  // Host D channels, one slice per host
  output logic [tl_pkg::NUM_HOSTS-1:0]                              host_d_valid_o,
  input  logic [tl_pkg::NUM_HOSTS-1:0]                              host_d_ready_i,
  output logic [tl_pkg::NUM_HOSTS-1:0][tl_pkg::OP_WIDTH-1:0]        host_d_opcode_o,
  output logic [tl_pkg::NUM_HOSTS-1:0][tl_pkg::HOST_SOURCE_WIDTH-1:0] host_d_source_o,
  output logic [tl_pkg::NUM_HOSTS-1:0][tl_pkg::DATA_WIDTH-1:0]      host_d_data_o
);

  import tl_pkg::*;

  logic [HOST_IDX_WIDTH-1:0]    dest_idx;
  logic [HOST_SOURCE_WIDTH-1:0] host_tag;

  // Upper source bits name the host, the rest is its own tag
  assign dest_idx = mem_d_source_i[SOURCE_WIDTH-1 -: HOST_IDX_WIDTH];
  assign host_tag = mem_d_source_i[HOST_SOURCE_WIDTH-1:0];

  assign mem_d_ready_o = host_d_ready_i[dest_idx];

  always_comb begin
    for (int h = 0; h < NUM_HOSTS; h++) begin
      host_d_valid_o[h]  = mem_d_valid_i && (dest_idx == HOST_IDX_WIDTH'(h));
      // Payload is shared, valid picks the receiver
      host_d_opcode_o[h] = mem_d_opcode_i;
      host_d_source_o[h] = host_tag;
      host_d_data_o[h]   = mem_d_data_i;
    end
  end

endmodule

//--- hdl/hpm_event_counter.sv
`timescale 1ns/1ps

module hpm_event_counter (
  input  logic clk_i,
  input  logic rst_n_i,

  // Internal strobes
  input  logic icache_access_i,
  input  logic dcache_access_i,
  input  logic mem_stall_i,

  input  logic [hpm_pkg::HPM_EVENT_NUM-1:0] hpm_event_i,

  // Counter i sits at bits [i*HPM_COUNTER_WIDTH +: HPM_COUNTER_WIDTH]
  output logic [hpm_pkg::HPM_EVENT_NUM*hpm_pkg::HPM_COUNTER_WIDTH-1:0] hpm_count_o
);

  import hpm_pkg::*;

  logic [HPM_EVENT_NUM-1:0]                        event_vec;
  logic [HPM_EVENT_NUM-1:0][HPM_COUNTER_WIDTH-1:0] count_q;

  always_comb begin
    event_vec = '0;
    // External bits pass through, the low ones are ours
    for (int i = HPM_EXT_FIRST; i < HPM_EVENT_NUM; i++) begin
      event_vec[i] = hpm_event_i[i];
    end
    event_vec[HPM_EVENT_NONE]          = 1'b0;
    event_vec[HPM_EVENT_ICACHE_ACCESS] = icache_access_i;
    event_vec[HPM_EVENT_DCACHE_ACCESS] = dcache_access_i;
    event_vec[HPM_EVENT_MEM_STALL]     = mem_stall_i;
  end

  // Saturating counters
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      count_q <= '0;
    end else begin
      for (int i = 0; i < HPM_EVENT_NUM; i++) begin
        if (event_vec[i] && (count_q[i] != '1)) begin
          count_q[i] <= count_q[i] + 1'b1;
        end
      end
    end
  end

  assign hpm_count_o = count_q;

endmodule

//--- hdl/core_mem_top.sv
`timescale 1ns/1ps

module core_mem_top (
  input  logic clk_i,
  input  logic rst_n_i,

  // Instruction fetch host
  input  logic                                 ic_a_valid_i,
  output logic                                 ic_a_ready_o,
  input  logic [tl_pkg::OP_WIDTH-1:0]          ic_a_opcode_i,
  input  logic [tl_pkg::ADDR_WIDTH-1:0]        ic_a_address_i,
  input  logic [tl_pkg::HOST_SOURCE_WIDTH-1:0] ic_a_source_i,
  input  logic [tl_pkg::DATA_WIDTH-1:0]        ic_a_data_i,
  output logic                                 ic_d_valid_o,
  input  logic                                 ic_d_ready_i,
  output logic [tl_pkg::OP_WIDTH-1:0]          ic_d_opcode_o,
  output logic [tl_pkg::HOST_SOURCE_WIDTH-1:0] ic_d_source_o,
  output logic [tl_pkg::DATA_WIDTH-1:0]        ic_d_data_o,

  // Data host
  input  logic                                 dc_a_valid_i,
  output logic                                 dc_a_ready_o,
  input  logic [tl_pkg::OP_WIDTH-1:0]          dc_a_opcode_i,
  input  logic [tl_pkg::ADDR_WIDTH-1:0]        dc_a_address_i,
  input  logic [tl_pkg::HOST_SOURCE_WIDTH-1:0] dc_a_source_i,
  input  logic [tl_pkg::DATA_WIDTH-1:0]        dc_a_data_i,
  output logic                                 dc_d_valid_o,
  input  logic                                 dc_d_ready_i,
  output logic [tl_pkg::OP_WIDTH-1:0]          dc_d_opcode_o,
  output logic [tl_pkg::HOST_SOURCE_WIDTH-1:0] dc_d_source_o,
  output logic [tl_pkg::DATA_WIDTH-1:0]        dc_d_data_o,

  // Memory port
  output logic                            mem_a_valid_o,
  input  logic                            mem_a_ready_i,
  output logic [tl_pkg::OP_WIDTH-1:0]     mem_a_opcode_o,
  output logic [tl_pkg::ADDR_WIDTH-1:0]   mem_a_address_o,
  output logic [tl_pkg::SOURCE_WIDTH-1:0] mem_a_source_o,
  output logic [tl_pkg::DATA_WIDTH-1:0]   mem_a_data_o,
  input  logic                            mem_d_valid_i,
  output logic                            mem_d_ready_o,
  input  logic [tl_pkg::OP_WIDTH-1:0]     mem_d_opcode_i,
  input  logic [tl_pkg::SOURCE_WIDTH-1:0] mem_d_source_i,
  input  logic [tl_pkg::DATA_WIDTH-1:0]   mem_d_data_i,

  input  logic [hpm_pkg::HPM_EVENT_NUM-1:0] hpm_event_i,
  output logic [hpm_pkg::HPM_EVENT_NUM*hpm_pkg::HPM_COUNTER_WIDTH-1:0] hpm_count_o
);

  logic icache_access;
  logic dcache_access;
  logic mem_stall;

  // Access counts completed A handshakes
  assign icache_access = ic_a_valid_i & ic_a_ready_o;
  assign dcache_access = dc_a_valid_i & dc_a_ready_o;
  assign mem_stall     = mem_d_valid_i & ~mem_d_ready_o;

  // Host 1 (data) in the upper slice, host 0 (fetch) in the lower
  tl_host_arbiter arbiter0 (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .host_a_valid_i   ({dc_a_valid_i, ic_a_valid_i}),
    .host_a_ready_o   ({dc_a_ready_o, ic_a_ready_o}),
    .host_a_opcode_i  ({dc_a_opcode_i, ic_a_opcode_i}),
    .host_a_address_i ({dc_a_address_i, ic_a_address_i}),
    .host_a_source_i  ({dc_a_source_i, ic_a_source_i}),
    .host_a_data_i    ({dc_a_data_i, ic_a_data_i}),
    .mem_a_valid_o    (mem_a_valid_o),
    .mem_a_ready_i    (mem_a_ready_i),
    .mem_a_opcode_o   (mem_a_opcode_o),
    .mem_a_address_o  (mem_a_address_o),
    .mem_a_source_o   (mem_a_source_o),
    .mem_a_data_o     (mem_a_data_o)
  );

  hpm_event_counter hpm0 (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .icache_access_i (icache_access),
    .dcache_access_i (dcache_access),
    .mem_stall_i     (mem_stall),
    .hpm_event_i     (hpm_event_i),
    .hpm_count_o     (hpm_count_o)
  );

  tl_resp_router router0 (
    .mem_d_valid_i   (mem_d_valid_i),
    .mem_d_ready_o   (mem_d_ready_o),
    .mem_d_opcode_i  (mem_d_opcode_i),
    .mem_d_source_i  (mem_d_source_i),
    .mem_d_data_i    (mem_d_data_i),
    .host_d_valid_o  ({dc_d_valid_o, ic_d_valid_o}),
    .host_d_ready_i  ({dc_d_ready_i, ic_d_ready_i}),
    .host_d_opcode_o ({dc_d_opcode_o, ic_d_opcode_o}),
    .host_d_source_o ({dc_d_source_o, ic_d_source_o}),
    .host_d_data_o   ({dc_d_data_o, ic_d_data_o})
  );

endmodule

//--- sim/core_mem_top_props.sv
`timescale 1ns/1ps

module core_mem_top_props (
  input logic                                 clk_i,
  input logic                                 rst_n_i,
  input logic [tl_pkg::NUM_HOSTS-1:0]         host_a_valid_i,
  input logic [tl_pkg::NUM_HOSTS-1:0]         host_a_ready_o,
  input logic                                 mem_a_valid_o,
  input logic                                 mem_a_ready_i,
  input logic [tl_pkg::OP_WIDTH-1:0]          mem_a_opcode_o,
  input logic [tl_pkg::ADDR_WIDTH-1:0]        mem_a_address_o,
  input logic [tl_pkg::SOURCE_WIDTH-1:0]      mem_a_source_o,
  input logic [tl_pkg::DATA_WIDTH-1:0]        mem_a_data_o
);

  import tl_pkg::*;

  // Stalled beat keeps its payload
  a_payload_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (mem_a_valid_o && !mem_a_ready_i) |=>
      $stable({mem_a_opcode_o, mem_a_address_o, mem_a_source_o, mem_a_data_o}))
    else $error("memory A payload changed while stalled");

  // Only the host named in the memory source may see ready
  a_one_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (|host_a_ready_o) |->
      (host_a_ready_o == (NUM_HOSTS'(1) << mem_a_source_o[SOURCE_WIDTH-1])))
    else $error("A ready went to a host other than the one on the memory channel");

  a_valid_source: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_a_valid_o |-> host_a_valid_i[mem_a_source_o[SOURCE_WIDTH-1]])
    else $error("memory A valid without A valid from the host named in the source");

endmodule

bind tl_host_arbiter core_mem_top_props props0 (
  .clk_i           (clk_i),
  .rst_n_i         (rst_n_i),
  .host_a_valid_i  (host_a_valid_i),
  .host_a_ready_o  (host_a_ready_o),
  .mem_a_valid_o   (mem_a_valid_o),
  .mem_a_ready_i   (mem_a_ready_i),
  .mem_a_opcode_o  (mem_a_opcode_o),
  .mem_a_address_o (mem_a_address_o),
  .mem_a_source_o  (mem_a_source_o),
  .mem_a_data_o    (mem_a_data_o)
);

//--- sim/core_mem_top_tb.sv
`timescale 1ns/1ps

module core_mem_top_tb;

  import tl_pkg::*;
  import hpm_pkg::*;

  logic clk_i;
  logic rst_n_i;

  // Index 0 is the fetch host and 1 the data host
  logic                         a_valid [2];
  logic                         a_ready [2];
  logic [OP_WIDTH-1:0]          a_op    [2];
  logic [ADDR_WIDTH-1:0]        a_addr  [2];
  logic [HOST_SOURCE_WIDTH-1:0] a_tag   [2];
  logic [DATA_WIDTH-1:0]        a_data  [2];
  logic                         d_valid [2];
  logic                         d_ready [2];
  logic [OP_WIDTH-1:0]          d_op    [2];
  logic [HOST_SOURCE_WIDTH-1:0] d_tag   [2];
  logic [DATA_WIDTH-1:0]        d_data  [2];

  logic                    mem_a_valid, mem_a_ready;
  logic [OP_WIDTH-1:0]     mem_a_op;
  logic [ADDR_WIDTH-1:0]   mem_a_addr;
  logic [SOURCE_WIDTH-1:0] mem_a_src;
  logic [DATA_WIDTH-1:0]   mem_a_data;
  logic                    mem_d_valid, mem_d_ready;
  logic [OP_WIDTH-1:0]     mem_d_op;
  logic [SOURCE_WIDTH-1:0] mem_d_src;
  logic [DATA_WIDTH-1:0]   mem_d_data;
  logic [HPM_EVENT_NUM-1:0] hpm_event;
  logic [HPM_EVENT_NUM*HPM_COUNTER_WIDTH-1:0] hpm_count;

  // Request entry is {op, addr, data, tag}
  logic [67:0]     req_buf [2][64];
  int              req_tail [2], issue_idx [2], beat_idx [2], done_cnt [2];
  logic            out_flag [2][2];
  logic [2:0]      exp_op   [2][2];
  logic [31:0]     exp_data [2][2];

  logic [31:0] mem [256];
  logic [1:0]  pend_src  [4];
  logic [2:0]  pend_op   [4];
  logic [31:0] pend_data [4];
  int          pend_dly  [4];
  int          pend_n, pres;
  logic        presenting, prev_fire, prev_host;

  logic [31:0] seed;
  int stall_cnt, mismatch_cnt, timeout_cnt, other_cnt;

  core_mem_top dut0 (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .ic_a_valid_i(a_valid[0]), .ic_a_ready_o(a_ready[0]), .ic_a_opcode_i(a_op[0]),
    .ic_a_address_i(a_addr[0]), .ic_a_source_i(a_tag[0]), .ic_a_data_i(a_data[0]),
    .ic_d_valid_o(d_valid[0]), .ic_d_ready_i(d_ready[0]), .ic_d_opcode_o(d_op[0]),
    .ic_d_source_o(d_tag[0]), .ic_d_data_o(d_data[0]),
    .dc_a_valid_i(a_valid[1]), .dc_a_ready_o(a_ready[1]), .dc_a_opcode_i(a_op[1]),
    .dc_a_address_i(a_addr[1]), .dc_a_source_i(a_tag[1]), .dc_a_data_i(a_data[1]),
    .dc_d_valid_o(d_valid[1]), .dc_d_ready_i(d_ready[1]), .dc_d_opcode_o(d_op[1]),
    .dc_d_source_o(d_tag[1]), .dc_d_data_o(d_data[1]),
    .mem_a_valid_o(mem_a_valid), .mem_a_ready_i(mem_a_ready), .mem_a_opcode_o(mem_a_op),
    .mem_a_address_o(mem_a_addr), .mem_a_source_o(mem_a_src), .mem_a_data_o(mem_a_data),
    .mem_d_valid_i(mem_d_valid), .mem_d_ready_o(mem_d_ready), .mem_d_opcode_i(mem_d_op),
    .mem_d_source_i(mem_d_src), .mem_d_data_i(mem_d_data),
    .hpm_event_i(hpm_event), .hpm_count_o(hpm_count)
  );

  always #50 clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] count_of(input int idx);
    return hpm_count[idx*HPM_COUNTER_WIDTH +: HPM_COUNTER_WIDTH];
  endfunction

  task automatic check_idle();
    assert (!mem_a_valid && !d_valid[0] && !d_valid[1] && hpm_count == '0) else begin
      $display("mismatch at %0t: valid output high or count nonzero around reset", $time);
      mismatch_cnt++;
    end
  endtask

  task automatic check_count(input int idx, input int expected);
    assert (count_of(idx) == 32'(expected)) else begin
      $display("mismatch at %0t: counter %0d is %0d, expected %0d",
               $time, idx, count_of(idx), expected);
      mismatch_cnt++;
    end
  endtask

  // Host, memory and monitor models step on the rising edge
  always @(posedge clk_i) begin : models
    logic [67:0] e;
    logic        fire;
    int          h, w, k, nready;
    if (rst_n_i) begin
      for (h = 0; h < 2; h++) begin
        if (d_valid[h] && d_ready[h]) begin
          assert (out_flag[h][d_tag[h]]) else begin
            $display("host %0d got a response for tag %0d with nothing outstanding", h, d_tag[h]);
            other_cnt++;
          end
          assert (d_op[h] == exp_op[h][d_tag[h]] &&
                  (d_op[h] == OP_ACCESS_ACK || d_data[h] == exp_data[h][d_tag[h]])) else begin
            $display("mismatch at %0t: host %0d tag %0d op %0d data %h, expected op %0d data %h",
                     $time, h, d_tag[h], d_op[h], d_data[h], exp_op[h][d_tag[h]],
                     exp_data[h][d_tag[h]]);
            mismatch_cnt++;
          end
          out_flag[h][d_tag[h]] = 1'b0;
          done_cnt[h]++;
        end
        seed = lcg_next(seed);
        d_ready[h] <= (seed[31:30] != 2'b00);
      end
      // A stall is a response whose host is not ready
      if (mem_d_valid && !d_ready[mem_d_src[1]]) stall_cnt++;
      // Retire the presented response
      if (mem_d_valid && mem_d_ready) begin
        for (k = pres; k < pend_n - 1; k++) begin
          pend_src[k] = pend_src[k+1];
          pend_op[k] = pend_op[k+1];
          pend_data[k] = pend_data[k+1];
          pend_dly[k] = pend_dly[k+1];
        end
        pend_n--;
        presenting = 1'b0;
      end
      for (k = 0; k < pend_n; k++) begin
        if (pend_dly[k] > 0) pend_dly[k]--;
      end
      fire = mem_a_valid && mem_a_ready;
      if (fire) begin
        h = int'(mem_a_src[1]);
        e = req_buf[h][beat_idx[h]];
        assert (beat_idx[h] < req_tail[h]) else begin
          $display("memory saw an extra beat from host %0d", h);
          other_cnt++;
        end
        assert (mem_a_op == e[67:65] && mem_a_addr == e[64:33] &&
                (mem_a_op == OP_GET || mem_a_data == e[32:1]) && mem_a_src[0] == e[0]) else begin
          $display("mismatch at %0t: host %0d beat %0d op %0d addr %h src %0d out of order",
                   $time, h, beat_idx[h], mem_a_op, mem_a_addr, mem_a_src);
          mismatch_cnt++;
        end
        if (prev_fire && a_valid[0] && a_valid[1]) begin
          assert (mem_a_src[1] != prev_host) else begin
            $display("mismatch at %0t: host %0d won twice in a row", $time, h);
            mismatch_cnt++;
          end
        end
        beat_idx[h]++;
        w = int'(mem_a_addr[9:2]);
        seed = lcg_next(seed);
        pend_src[pend_n] = mem_a_src;
        pend_dly[pend_n] = int'(seed[31:30]);
        if (mem_a_op == OP_GET) begin
          pend_op[pend_n] = OP_ACCESS_ACK_DATA;
          pend_data[pend_n] = mem[w];
        end else begin
          pend_op[pend_n] = OP_ACCESS_ACK;
          pend_data[pend_n] = '0;
          mem[w] = mem_a_data;
        end
        pend_n++;
        prev_host = mem_a_src[1];
      end
      prev_fire = fire;
      // Pick one of the due responses in LCG order
      if (!presenting) begin
        nready = 0;
        for (k = 0; k < pend_n; k++) begin
          if (pend_dly[k] == 0) nready++;
        end
        mem_d_valid <= 1'b0;
        if (nready > 0) begin
          seed = lcg_next(seed);
          w = int'(seed[23:16]) % nready;
          for (k = 0; k < pend_n; k++) begin
            if (pend_dly[k] == 0 && !presenting) begin
              if (w == 0) begin
                pres = k;
                presenting = 1'b1;
                mem_d_valid <= 1'b1;
                mem_d_src <= pend_src[k];
                mem_d_op <= pend_op[k];
                mem_d_data <= pend_data[k];
              end
              w--;
            end
          end
        end
      end
      seed = lcg_next(seed);
      mem_a_ready <= (pend_n < 4) && (seed[31:30] != 2'b00);
      for (h = 0; h < 2; h++) begin
        if (!a_valid[h] || a_ready[h]) begin
          a_valid[h] <= 1'b0;
          if (issue_idx[h] < req_tail[h]) begin
            e = req_buf[h][issue_idx[h]];
            if (!out_flag[h][e[0]]) begin
              a_valid[h] <= 1'b1;
              a_op[h] <= e[67:65];
              a_addr[h] <= e[64:33];
              a_data[h] <= e[32:1];
              a_tag[h] <= e[0];
              out_flag[h][e[0]] = 1'b1;
              exp_op[h][e[0]] = (e[67:65] == OP_GET) ? OP_ACCESS_ACK_DATA : OP_ACCESS_ACK;
              exp_data[h][e[0]] = e[32:1];
              issue_idx[h]++;
            end
          end
        end
      end
    end
  end

  initial begin
    int fd, h, tag, len, ic_cnt, dc_cnt, wait_cnt, i;
    int ext_cnt [4];
    logic [31:0] op, addr, data, ext;
    logic        abort;
    string       line;
    clk_i = 1'b0;
    rst_n_i = 1'b0;
    seed = 32'h885a755d;
    abort = 1'b0;
    for (h = 0; h < 2; h++) begin
      a_valid[h] = 1'b0;
      a_op[h] = '0;
      a_addr[h] = '0;
      a_tag[h] = '0;
      a_data[h] = '0;
      d_ready[h] = 1'b0;
      req_tail[h] = 0;
      issue_idx[h] = 0;
      beat_idx[h] = 0;
      done_cnt[h] = 0;
      out_flag[h][0] = 1'b0;
      out_flag[h][1] = 1'b0;
    end
    mem_a_ready = 1'b0;
    mem_d_valid = 1'b0;
    mem_d_op = '0;
    mem_d_src = '0;
    mem_d_data = '0;
    hpm_event = '0;
    pend_n = 0;
    pres = 0;
    presenting = 1'b0;
    prev_fire = 1'b0;
    prev_host = 1'b0;
    stall_cnt = 0;
    mismatch_cnt = 0;
    timeout_cnt = 0;
    other_cnt = 0;
    for (i = 0; i < 256; i++) mem[i] = 32'hc0de0000 | 32'(i);

    for (i = 0; i < 8; i++) begin
      @(negedge clk_i);
      check_idle();
    end
    @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    check_idle();

    fd = $fopen("sim/core_mem_trace.txt", "r");
    if (fd == 0) begin
      $display("could not open the trace file sim/core_mem_trace.txt");
      other_cnt++;
      abort = 1'b1;
    end
    while (!abort && $fgets(line, fd) != 0) begin
      if (line.len() > 0 && line[0] == "R") begin
        void'($sscanf(line, "R %h %h %h %h %h", h, op, addr, data, tag));
        req_buf[h][req_tail[h]] = {op[2:0], addr, data, tag[0]};
        req_tail[h]++;
      end else if (line.len() > 0 && line[0] == "P") begin
        void'($sscanf(line, "P %h %h %h %h %h %h %h %h", ext, len, ic_cnt, dc_cnt,
                      ext_cnt[0], ext_cnt[1], ext_cnt[2], ext_cnt[3]));
        // Let every request finish before the event window
        wait_cnt = 0;
        while (!(issue_idx[0] == req_tail[0] && issue_idx[1] == req_tail[1] &&
                 done_cnt[0] == req_tail[0] && done_cnt[1] == req_tail[1] &&
                 pend_n == 0 && !mem_d_valid && !a_valid[0] && !a_valid[1]) &&
               wait_cnt < 2000) begin
          @(negedge clk_i);
          wait_cnt++;
        end
        if (wait_cnt >= 2000) begin
          $display("timed out waiting for all requests to get their responses");
          timeout_cnt++;
          abort = 1'b1;
        end else begin
          @(posedge clk_i);
          hpm_event <= ext[HPM_EVENT_NUM-1:0];
          repeat (len) @(posedge clk_i);
          hpm_event <= '0;
          @(negedge clk_i);
          check_count(HPM_EVENT_NONE, 0);
          check_count(HPM_EVENT_ICACHE_ACCESS, ic_cnt);
          check_count(HPM_EVENT_DCACHE_ACCESS, dc_cnt);
          check_count(HPM_EVENT_MEM_STALL, stall_cnt);
          for (i = 0; i < 4; i++) check_count(HPM_EXT_FIRST + i, ext_cnt[i]);
        end
      end
    end
    if (fd != 0) $fclose(fd);

    $display("errors: mismatch %0d, timeout %0d, other %0d",
             mismatch_cnt, timeout_cnt, other_cnt);
    if (mismatch_cnt == 0 && timeout_cnt == 0 && other_cnt == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- core_mem_top.f
hdl/tl_pkg.sv
hdl/hpm_pkg.sv
hdl/tl_host_arbiter.sv
hdl/tl_resp_router.sv
hdl/hpm_event_counter.sv
hdl/core_mem_top.sv
sim/core_mem_top_props.sv
sim/core_mem_top_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the core_mem_top testbench with Verilator.
# The run passes only if the log holds the pass line.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
  --top-module core_mem_top_tb \
  -Mdir obj_dir -o sim_core_mem \
  -f core_mem_top.f
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_core_mem > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^=== PASS ===$" "$LOG"; then
  exit 0
fi
exit 1

//--- sim/core_mem_trace.txt
# R host op addr data tag : one request, data is the expected read data for a Get
# P ext len ic_cnt dc_cnt e4 e5 e6 e7 : event phase with cumulative expected counts (hex)
R 0 4 00000040 c0de0010 0
R 1 0 00000100 11111111 0
R 0 4 00000044 c0de0011 1
R 1 0 00000104 22222222 1
R 0 4 00000048 c0de0012 0
R 1 4 00000100 11111111 0
R 0 4 0000004c c0de0013 1
R 1 0 00000100 33333333 1
R 1 4 00000100 33333333 0
P 00 1 4 5 0 0 0 0
R 0 4 00000104 22222222 0
R 1 0 00000108 44444444 1
R 0 4 00000100 33333333 1
R 1 4 00000108 44444444 0
R 0 4 00000050 c0de0014 0
R 1 4 00000104 22222222 1
P a0 5 7 8 0 5 0 5
P 50 3 7 8 3 5 3 5
P f3 2 7 8 5 7 5 7
